// File: sources.f
src/dac_pkg.sv
src/dac_wr_if.sv
src/dac_wr_arbiter.sv
src/dac_cmd_regfile.sv
src/dac_host_port.sv
src/dac_spi_chain.sv
src/dac_ctrl_top.sv
dv/dac_ctrl_properties.sv
dv/dac_ctrl_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the DAC controller testbench with Verilator, run it and check the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -f sources.f --top-module dac_ctrl_tb -Mdir obj_dir \
    || { echo "verilator build failed"; exit 1; }

./obj_dir/Vdac_ctrl_tb > "$LOG" 2>&1
cat "$LOG"

grep -qx "TEST PASSED" "$LOG" \
    && echo "result: pass" \
    || { echo "result: fail"; exit 1; }

// File: dv/dac_ctrl_tb.sv
/*
 * dac controller testbench
 * host writes, block triggers and readback against a model of the
 * live and copy words, with the spi frame captured bit by bit
 */

`timescale 1ns/1ps

module dac_ctrl_tb
    import dac_pkg::*;
();

    localparam int NUM_CHANNELS = 4;
    localparam int FRAME_W      = 32 * NUM_CHANNELS;
    localparam int WAIT_LIMIT   = 2000;   // sysclk cycles per wait
    localparam int READ_LIMIT   = 4;      // write shows on readback within 4 cycles

    localparam logic [31:0] NOP_WORD = 32'h00F0_8000;  // reset and flush word
    localparam logic [3:0]  CMD_WRU  = 4'h3;           // write and update

    logic                          sysclk;
    logic                          rst;
    logic                          reg_wen;
    logic                          blk_wen;
    logic [15:0]                   reg_waddr;
    logic [15:0]                   reg_wdata;
    logic [3:0]                    reg_rchan;
    logic [31:0]                   reg_rdata;
    logic                          sclk;
    logic                          mosi;
    logic                          csel;
    logic                          busy;
    logic [NUM_CHANNELS-1:0][15:0] dac_val;

    integer             seed;
    logic [31:0]        live_exp [NUM_CHANNELS];  // words the next frame sends
    logic [31:0]        copy_exp [NUM_CHANNELS];  // last host word per channel
    logic [FRAME_W-1:0] frame_cap;
    int                 frame_bits;
    int                 frame_count;
    logic               sclk_q;
    logic               csel_q;

    dac_ctrl_top UUT
    (
        .sysclk    (sysclk),
        .rst       (rst),
        .reg_wen   (reg_wen),
        .blk_wen   (blk_wen),
        .reg_waddr (reg_waddr),
        .reg_wdata (reg_wdata),
        .reg_rchan (reg_rchan),
        .reg_rdata (reg_rdata),
        .sclk      (sclk),
        .mosi      (mosi),
        .csel      (csel),
        .busy      (busy),
        .dac_val   (dac_val)
    );

    initial
    begin
        sysclk = 1'b0;
        forever #4 sysclk = ~sysclk;   // 8 ns period
    end

    // ------------------------------
    // spi capture
    // ------------------------------
    always @(posedge sysclk)
    begin
        if (rst)
        begin
            frame_cap   <= '0;
            frame_bits  <= 0;
            frame_count <= 0;
        end
        else if (!csel && csel_q)
        begin
            frame_cap  <= '0;                               // new frame
            frame_bits <= 0;
        end
        else if (!csel && sclk && !sclk_q)
        begin
            frame_cap  <= {frame_cap[FRAME_W-2:0], mosi};  // msb first
            frame_bits <= frame_bits + 1;
        end
        else if (csel && !csel_q)
            frame_count <= frame_count + 1;                // frame closed
        sclk_q <= rst ? 1'b0 : sclk;
        csel_q <= rst ? 1'b1 : csel;
    end

    // ------------------------------
    // helpers
    // ------------------------------
    task automatic report_failure(input string line);
        $display("%s", line);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    // command in 23:20, value in 15:0, rest zero
    function automatic logic [31:0] expected_wru(input logic [15:0] val);
        logic [31:0] w;
        w        = '0;
        w[23:20] = CMD_WRU;
        w[15:0]  = val;
        return w;
    endfunction

    function automatic logic [15:0] dac_addr(input int ch);
        return {ADDR_MAIN, 4'h0, 4'(ch), OFF_DAC_CTRL};
    endfunction

    // last channel leads the chain
    function automatic logic [FRAME_W-1:0] expected_frame();
        logic [FRAME_W-1:0] f;
        f = '0;
        for (int i = NUM_CHANNELS - 1; i >= 0; i--)
            f = {f[FRAME_W-33:0], live_exp[i]};
        return f;
    endfunction

    // one-cycle bus access
    task automatic drive_bus(input logic wen, input logic blk, input logic [15:0] addr,
                             input logic [15:0] data);
        @(posedge sysclk);
        #1;
        reg_wen   = wen;
        blk_wen   = blk;
        reg_waddr = addr;
        reg_wdata = data;
        @(posedge sysclk);
        #1;
        reg_wen = 1'b0;
        blk_wen = 1'b0;
    endtask

    task automatic read_channel(input int ch, output logic [31:0] word,
                                output logic [15:0] lane);
        @(posedge sysclk);
        #1;
        reg_rchan = 4'(ch);
        @(negedge sysclk);    // mid cycle, readback settled
        word = reg_rdata;
        lane = dac_val[ch-1];
    endtask

    task automatic check_readback(input int ch);
        logic [31:0] word;
        logic [15:0] lane;
        read_channel(ch, word, lane);
        assert (word === copy_exp[ch-1])
            else report_failure($sformatf("ERR at time %0t: reg_rdata ch%0d is %h, expected %h",
                                          $time, ch, word, copy_exp[ch-1]));
        assert (lane === copy_exp[ch-1][15:0])
            else report_failure($sformatf("ERR at time %0t: dac_val ch%0d is %h, expected %h",
                                          $time, ch, lane, copy_exp[ch-1][15:0]));
    endtask

    task automatic check_all_readback();
        for (int ch = 1; ch <= NUM_CHANNELS; ch++)
            check_readback(ch);
    endtask

    task automatic wait_busy(input logic level);
        int n;
        n = 0;
        while (busy !== level && n < WAIT_LIMIT)
        begin
            @(posedge sysclk);
            #1;
            n++;
        end
        if (busy !== level)
            report_failure($sformatf("timeout: busy did not go to %0b within %0d cycles",
                                     level, WAIT_LIMIT));
    endtask

    // host side of the four-phase handshake back at rest
    task automatic wait_host_idle();
        int n;
        n = 0;
        while ((UUT.wr_host.req || UUT.wr_host.ack) && n < WAIT_LIMIT)
        begin
            @(posedge sysclk);
            #1;
            n++;
        end
        if (UUT.wr_host.req || UUT.wr_host.ack)
            report_failure("timeout: host write handshake never returned to idle");
    endtask

    task automatic host_write(input int ch, input logic [15:0] val, input logic blk);
        logic [31:0] word;
        logic [15:0] lane;
        int          n;
        copy_exp[ch-1] = expected_wru(val);
        live_exp[ch-1] = expected_wru(val);
        drive_bus(1'b1, blk, dac_addr(ch), val);
        word = '0;
        lane = '0;
        n    = 0;
        while (word !== copy_exp[ch-1] && n < READ_LIMIT)
        begin
            read_channel(ch, word, lane);
            n++;
        end
        assert (word === copy_exp[ch-1] && lane === val)
            else report_failure($sformatf("ERR at time %0t: write ch%0d shows %h / %h, expected %h",
                                          $time, ch, word, lane, copy_exp[ch-1]));
        wait_host_idle();
    endtask

    // frame already running, check it once busy falls
    task automatic finish_frame(input logic [FRAME_W-1:0] exp);
        int start_count;
        start_count = frame_count;
        wait_busy(1'b0);
        @(posedge sysclk);
        #1;
        assert (frame_count == start_count + 1 && csel === 1'b1)
            else report_failure($sformatf("ERR at time %0t: %0d frames seen, expected one",
                                          $time, frame_count - start_count));
        assert (frame_bits == FRAME_W)
            else report_failure($sformatf("ERR at time %0t: frame has %0d bits, expected %0d",
                                          $time, frame_bits, FRAME_W));
        assert (frame_cap === exp)
            else report_failure($sformatf("ERR at time %0t: frame %h, expected %h",
                                          $time, frame_cap, exp));
        for (int i = 0; i < NUM_CHANNELS; i++)
            live_exp[i] = NOP_WORD;   // every sent word is flushed
    endtask

    // ------------------------------
    // stimulus
    // ------------------------------
    initial
    begin
        logic [15:0]        val;
        logic [FRAME_W-1:0] exp;
        int                 order [NUM_CHANNELS];
        int                 j;
        int                 tmp;
        int                 ch;
        seed      = 72514;
        rst       = 1'b1;
        reg_wen   = 1'b0;
        blk_wen   = 1'b0;
        reg_waddr = '0;
        reg_wdata = '0;
        reg_rchan = 4'd1;
        for (int i = 0; i < NUM_CHANNELS; i++)
        begin
            live_exp[i] = NOP_WORD;
            copy_exp[i] = NOP_WORD;
        end
        repeat (5) @(posedge sysclk);
        #1;
        rst = 1'b0;

        // reset state
        check_all_readback();
        assert (csel === 1'b1 && busy === 1'b0 && sclk === 1'b0 && mosi === 1'b0)
            else report_failure($sformatf("ERR at time %0t: spi pins not idle after reset", $time));

        // random order, last channel of the shuffle stays unwritten
        for (int i = 0; i < NUM_CHANNELS; i++)
            order[i] = i + 1;
        for (int i = NUM_CHANNELS - 1; i > 0; i--)
        begin
            j        = int'($unsigned($random(seed)) % (i + 1));
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int i = 0; i < NUM_CHANNELS - 1; i++)
        begin
            val = 16'($random(seed));
            host_write(order[i], val, 1'b0);
        end
        check_all_readback();

        // first frame carries the host words
        exp = expected_frame();
        drive_bus(1'b0, 1'b1, dac_addr(0), 16'h0000);
        wait_busy(1'b1);
        finish_frame(exp);
        check_all_readback();

        // second frame all nop, readback keeps host values
        exp = expected_frame();
        drive_bus(1'b0, 1'b1, dac_addr(0), 16'h0000);
        wait_busy(1'b1);
        finish_frame(exp);
        check_all_readback();

        // writes during a transaction are dropped
        exp = expected_frame();
        drive_bus(1'b0, 1'b1, dac_addr(0), 16'h0000);
        wait_busy(1'b1);
        for (int c = 1; c <= NUM_CHANNELS; c++)
            drive_bus(1'b1, 1'b0, dac_addr(c), 16'($random(seed)));
        finish_frame(exp);
        check_all_readback();

        // wrong block nibble, then wrong offset nibble
        drive_bus(1'b1, 1'b0, {~ADDR_MAIN, 4'h0, 4'h1, OFF_DAC_CTRL}, 16'($random(seed)));
        drive_bus(1'b1, 1'b0, {ADDR_MAIN, 4'h0, 4'h2, ~OFF_DAC_CTRL}, 16'($random(seed)));
        repeat (4) @(posedge sysclk);
        check_all_readback();

        // quadlet write and block trigger in one cycle
        ch  = int'($unsigned($random(seed)) % NUM_CHANNELS) + 1;
        val = 16'($random(seed));
        host_write(ch, val, 1'b1);
        exp = expected_frame();
        wait_busy(1'b1);
        finish_frame(exp);
        check_all_readback();

        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: dv/dac_ctrl_properties.sv
/*
 * dac controller properties
 * four-phase ordering on both regfile write requesters, one ack at a time,
 * and spi frame framing rules for sclk, csel and busy
 */

`timescale 1ns/1ps

module dac_ctrl_properties
(
    input logic sysclk,
    input logic rst,
    input logic host_req,
    input logic host_ack,
    input logic flush_req,
    input logic flush_ack,
    input logic sclk,
    input logic csel,
    input logic busy
);

    // ------------------------------
    // host handshake
    // ------------------------------
    a_host_rise: assert property (@(posedge sysclk) disable iff (rst)
        $rose(host_req) |-> !host_ack)
        else $error("host req raised while ack still high");
    a_host_hold: assert property (@(posedge sysclk) disable iff (rst)
        host_req && !host_ack |=> host_req)
        else $error("host req dropped before ack");
    a_host_ack: assert property (@(posedge sysclk) disable iff (rst)
        $rose(host_ack) |-> host_req)
        else $error("host ack raised without req");
    a_host_keep: assert property (@(posedge sysclk) disable iff (rst)
        host_ack && host_req |=> host_ack)
        else $error("host ack dropped while req high");
    a_host_drop: assert property (@(posedge sysclk) disable iff (rst)
        host_ack && !host_req |=> !host_ack)
        else $error("host ack held after req fell");

    // ------------------------------
    // flush handshake
    // ------------------------------
    a_flush_rise: assert property (@(posedge sysclk) disable iff (rst)
        $rose(flush_req) |-> !flush_ack)
        else $error("flush req raised while ack still high");
    a_flush_hold: assert property (@(posedge sysclk) disable iff (rst)
        flush_req && !flush_ack |=> flush_req)
        else $error("flush req dropped before ack");
    a_flush_ack: assert property (@(posedge sysclk) disable iff (rst)
        $rose(flush_ack) |-> flush_req)
        else $error("flush ack raised without req");
    a_flush_keep: assert property (@(posedge sysclk) disable iff (rst)
        flush_ack && flush_req |=> flush_ack)
        else $error("flush ack dropped while req high");
    a_flush_drop: assert property (@(posedge sysclk) disable iff (rst)
        flush_ack && !flush_req |=> !flush_ack)
        else $error("flush ack held after req fell");

    // one owner of the write port
    a_one_ack: assert property (@(posedge sysclk) disable iff (rst)
        !(host_ack && flush_ack))
        else $error("both requesters acked at once");

    // ------------------------------
    // spi framing
    // ------------------------------
    a_sclk_quiet: assert property (@(posedge sysclk) disable iff (rst)
        csel |-> $stable(sclk))
        else $error("sclk toggled with csel high");
    a_busy_frame: assert property (@(posedge sysclk) disable iff (rst)
        !csel |-> busy)
        else $error("csel low while busy low");

endmodule

// arbiter handshakes are visible at the top as the two interface instances
bind dac_ctrl_top dac_ctrl_properties u_props
(
    .sysclk    (sysclk),
    .rst       (rst),
    .host_req  (wr_host.req),
    .host_ack  (wr_host.ack),
    .flush_req (wr_flush.req),
    .flush_ack (wr_flush.ack),
    .sclk      (sclk),
    .csel      (csel),
    .busy      (busy)
);

// File: src/dac_ctrl_top.sv
/*
 * dac chain controller top
 * host port, spi serializer, write arbiter and command regfile
 */

`timescale 1ns/1ps

module dac_ctrl_top
    import dac_pkg::*;
#(
    parameter int  NUM_CHANNELS = 4,
    parameter int  SCLK_DIV     = 2,
    localparam int CW           = chan_w(NUM_CHANNELS)
)
(
    input  logic                          sysclk,
    input  logic                          rst,
    // host register bus
    input  logic                          reg_wen,
    input  logic                          blk_wen,
    input  logic [15:0]                   reg_waddr,
    input  logic [15:0]                   reg_wdata,
    input  logic [3:0]                    reg_rchan,   // 1-based
    output logic [31:0]                   reg_rdata,
    // spi
    output logic                          sclk,
    output logic                          mosi,
    output logic                          csel,
    output logic                          busy,
    output logic [NUM_CHANNELS-1:0][15:0] dac_val
);

    // ------------------------------
    // internal wiring
    // ------------------------------
    logic          trig;
    logic          we;
    logic [CW-1:0] waddr;
    dac_word_t     wdata;
    logic          copy_en;
    logic [CW-1:0] rd_chan;
    dac_word_t     rd_word;

    dac_wr_if #(.NUM_CHANNELS(NUM_CHANNELS)) wr_host ();   // host port side
    dac_wr_if #(.NUM_CHANNELS(NUM_CHANNELS)) wr_flush ();  // serializer side

    dac_host_port #(.NUM_CHANNELS(NUM_CHANNELS)) u_host_port
    (
        .sysclk    (sysclk),
        .rst       (rst),
        .reg_wen   (reg_wen),
        .blk_wen   (blk_wen),
        .reg_waddr (reg_waddr),
        .reg_wdata (reg_wdata),
        .busy      (busy),
        .wr        (wr_host.requester),
        .trig      (trig)
    );

    dac_spi_chain #(.NUM_CHANNELS(NUM_CHANNELS), .SCLK_DIV(SCLK_DIV)) u_spi_chain
    (
        .sysclk  (sysclk),
        .rst     (rst),
        .trig    (trig),
        .rd_chan (rd_chan),
        .rd_word (rd_word),
        .flush   (wr_flush.requester),
        .sclk    (sclk),
        .mosi    (mosi),
        .csel    (csel),
        .busy    (busy)
    );

    dac_wr_arbiter #(.NUM_CHANNELS(NUM_CHANNELS)) u_wr_arbiter
    (
        .sysclk  (sysclk),
        .rst     (rst),
        .host    (wr_host.arbiter),
        .flush   (wr_flush.arbiter),
        .we      (we),
        .waddr   (waddr),
        .wdata   (wdata),
        .copy_en (copy_en)
    );

    dac_cmd_regfile #(.NUM_CHANNELS(NUM_CHANNELS)) u_cmd_regfile
    (
        .sysclk  (sysclk),
        .rst     (rst),
        .we      (we),
        .waddr   (waddr),
        .wdata   (wdata),
        .copy_en (copy_en),
        .rd_chan (rd_chan),
        .rd_word (rd_word),
        .rb_chan (reg_rchan),
        .rb_word (reg_rdata),
        .dac_val (dac_val)
    );

endmodule

// File: src/dac_spi_chain.sv
/*
 * spi chain serializer
 * shifts every channel word out under one chip select, last channel
 * first, and flushes each channel to nop after its word is sent
 */

`timescale 1ns/1ps

module dac_spi_chain
    import dac_pkg::*;
#(
    parameter int  NUM_CHANNELS = 4,
    parameter int  SCLK_DIV     = 2,      // sclk half period in sysclk cycles
    localparam int CW           = chan_w(NUM_CHANNELS)
)
(
    input  logic          sysclk,
    input  logic          rst,
    input  logic          trig,
    output logic [CW-1:0] rd_chan,        // live word select
    input  dac_word_t     rd_word,
    dac_wr_if.requester   flush,
    output logic          sclk,
    output logic          mosi,
    output logic          csel,           // active low
    output logic          busy
);

    localparam int DIV_W = $clog2(SCLK_DIV + 1);

    typedef enum logic [1:0]
    {
        ST_IDLE,
        ST_LOAD,
        ST_SHIFT,
        ST_FLUSH
    } state_t;

    state_t          state;
    logic [DIV_W-1:0] div_cnt;
    logic             div_tick;  // half period elapsed
    logic [4:0]       bit_cnt;   // bits left after the current one
    logic [CW-1:0]    chan;
    logic             flush_req;
    dac_word_t        shreg;     // msb is on mosi

    assign div_tick = (div_cnt == DIV_W'(SCLK_DIV - 1));

    assign rd_chan    = chan;
    assign flush.req  = flush_req;
    assign flush.addr = chan;
    assign flush.data = DAC_WORD_NOP;

    // ------------------------------
    // control fsm
    // ------------------------------
    always_ff @(posedge sysclk)
    begin
        if (rst)
        begin
            state     <= ST_IDLE;
            div_cnt   <= '0;
            bit_cnt   <= '0;
            chan      <= '0;
            flush_req <= 1'b0;
            sclk      <= 1'b0;
            mosi      <= 1'b0;
            csel      <= 1'b1;
            busy      <= 1'b0;
        end
        else
        begin
            unique case (state)
                ST_IDLE:
                begin
                    if (trig)
                    begin
                        chan  <= CW'(NUM_CHANNELS - 1);  // last channel leads
                        csel  <= 1'b0;
                        busy  <= 1'b1;
                        state <= ST_LOAD;
                    end
                end
                ST_LOAD:
                begin
                    mosi    <= rd_word[31];              // first bit before first rise
                    bit_cnt <= 5'd31;
                    div_cnt <= '0;
                    state   <= ST_SHIFT;
                end
                ST_SHIFT:
                begin
                    div_cnt <= div_tick ? '0 : div_cnt + 1'b1;
                    if (div_tick)
                    begin
                        sclk <= ~sclk;
                        if (sclk)                        // falling edge, next bit
                        begin
                            if (bit_cnt == 5'd0)
                            begin
                                flush_req <= 1'b1;       // word done, nop it
                                state     <= ST_FLUSH;
                            end
                            else
                            begin
                                mosi    <= shreg[30];
                                bit_cnt <= bit_cnt - 1'b1;
                            end
                        end
                    end
                end
                ST_FLUSH:
                begin
                    // sclk parked low until the handshake closes
                    if (flush_req && flush.ack)
                        flush_req <= 1'b0;
                    else if (!flush_req && !flush.ack)
                    begin
                        if (chan == '0)
                        begin
                            mosi  <= 1'b0;
                            csel  <= 1'b1;               // frame ends
                            busy  <= 1'b0;
                            state <= ST_IDLE;
                        end
                        else
                        begin
                            chan  <= chan - 1'b1;
                            state <= ST_LOAD;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // shift register, loaded then moved on each falling edge
    always_ff @(posedge sysclk)
    begin
        if (state == ST_LOAD)
            shreg <= rd_word;
        else if (state == ST_SHIFT && div_tick && sclk && bit_cnt != 5'd0)
            shreg <= {shreg[30:0], 1'b0};
    end

endmodule

// File: src/dac_host_port.sv
/*
 * host register port
 * decodes dac control writes into write-and-update requests and
 * turns block writes into a serializer trigger once the write lands
 */

`timescale 1ns/1ps

module dac_host_port
    import dac_pkg::*;
#(
    parameter int  NUM_CHANNELS = 4,
    localparam int CW           = chan_w(NUM_CHANNELS)
)
(
    input  logic         sysclk,
    input  logic         rst,
    input  logic         reg_wen,    // quadlet write
    input  logic         blk_wen,    // end of block write
    input  logic [15:0]  reg_waddr,
    input  logic [15:0]  reg_wdata,
    input  logic         busy,       // spi transaction running
    dac_wr_if.requester  wr,
    output logic         trig        // one-cycle start pulse
);

    // ------------------------------
    // address decode
    // ------------------------------
    logic       addr_hit;   // main block, dac ctrl offset
    logic [3:0] chan_nib;   // 1-based channel
    logic [3:0] chan_z;     // zero-based channel
    logic       chan_ok;
    logic       wr_busy;    // own handshake still open
    logic       wr_go;      // accept a write this cycle
    logic       blk_hit;
    logic       blk_pend;   // trigger waits for the write to finish
    logic       req_r;

    assign addr_hit = (reg_waddr[15:12] == ADDR_MAIN) && (reg_waddr[3:0] == OFF_DAC_CTRL);
    assign chan_nib = reg_waddr[7:4];
    assign chan_z   = chan_nib - 4'd1;
    assign chan_ok  = (chan_nib != 4'd0) && (int'(chan_nib) <= NUM_CHANNELS);

    assign wr_busy = req_r || wr.ack;
    assign wr_go   = reg_wen && addr_hit && chan_ok && !busy && !wr_busy;
    assign blk_hit = blk_wen && addr_hit && !busy;

    assign wr.req = req_r;

    // request side of the handshake
    always_ff @(posedge sysclk)
    begin
        if (rst)
            req_r <= 1'b0;
        else if (wr_go)
            req_r <= 1'b1;
        else if (req_r && wr.ack)
            req_r <= 1'b0;                 // ack seen, let go
    end

    // payload held stable while req is high
    always_ff @(posedge sysclk)
    begin
        if (wr_go)
        begin
            wr.addr <= CW'(chan_z);
            wr.data <= dac_wru_word(reg_wdata);
        end
    end

    // ------------------------------
    // trigger sequencing
    // ------------------------------
    always_ff @(posedge sysclk)
    begin
        if (rst)
        begin
            trig     <= 1'b0;
            blk_pend <= 1'b0;
        end
        else
        begin
            trig <= 1'b0;
            if (blk_hit || blk_pend)
            begin
                if (!wr_go && !wr_busy)
                begin
                    trig     <= 1'b1;      // write landed, go
                    blk_pend <= 1'b0;
                end
                else
                    blk_pend <= 1'b1;
            end
        end
    end

endmodule

// File: src/dac_cmd_regfile.sv
/*
 * dac command register file
 * live words feed the serializer and are flushed to nop after use,
 * a second copy keeps the last host word for readback and dac_val
 */

`timescale 1ns/1ps

module dac_cmd_regfile
    import dac_pkg::*;
#(
    parameter int  NUM_CHANNELS = 4,
    localparam int CW           = chan_w(NUM_CHANNELS)
)
(
    input  logic                               sysclk,
    input  logic                               rst,
    // write port from the arbiter
    input  logic                               we,
    input  logic [CW-1:0]                      waddr,
    input  dac_word_t                          wdata,
    input  logic                               copy_en,
    // serializer read port
    input  logic [CW-1:0]                      rd_chan,
    output dac_word_t                          rd_word,
    // host readback, 1-based channel
    input  logic [3:0]                         rb_chan,
    output dac_word_t                          rb_word,
    output logic [NUM_CHANNELS-1:0][15:0]      dac_val
);

    dac_word_t  live_mem [NUM_CHANNELS];  // flushed after each shift
    dac_word_t  copy_mem [NUM_CHANNELS];  // host writes only
    logic [3:0] rb_idx;                   // zero-based readback channel
    logic       rb_ok;

    // ------------------------------
    // write side
    // ------------------------------
    always_ff @(posedge sysclk)
    begin
        if (rst)
        begin
            for (int i = 0; i < NUM_CHANNELS; i++)
            begin
                live_mem[i] <= DAC_WORD_NOP;
                copy_mem[i] <= DAC_WORD_NOP;
            end
        end
        else if (we && (int'(waddr) < NUM_CHANNELS))
        begin
            live_mem[waddr] <= wdata;
            if (copy_en)
                copy_mem[waddr] <= wdata;  // readback keeps host value
        end
    end

    // ------------------------------
    // read side
    // ------------------------------
    assign rd_word = live_mem[rd_chan];

    assign rb_idx  = rb_chan - 4'd1;
    assign rb_ok   = (rb_chan != 4'd0) && (int'(rb_chan) <= NUM_CHANNELS);
    assign rb_word = rb_ok ? copy_mem[CW'(rb_idx)] : '0;  // out of range reads zero

    // current per channel, low half of the copy
    always_comb
    begin
        for (int i = 0; i < NUM_CHANNELS; i++)
            dac_val[i] = copy_mem[i][15:0];
    end

endmodule

// File: src/dac_wr_arbiter.sv
/*
 * regfile write arbiter
 * merges the host and flush requesters onto the single write port,
 * flush first, with a four-phase handshake on each side
 */

`timescale 1ns/1ps

module dac_wr_arbiter
    import dac_pkg::*;
#(
    parameter int  NUM_CHANNELS = 4,
    localparam int CW           = chan_w(NUM_CHANNELS)
)
(
    input  logic          sysclk,
    input  logic          rst,
    dac_wr_if.arbiter     host,     // host port requests
    dac_wr_if.arbiter     flush,    // serializer nop flush requests
    output logic          we,       // one-cycle write strobe
    output logic [CW-1:0] waddr,
    output dac_word_t     wdata,
    output logic          copy_en   // host writes also hit the readback copy
);

    // ------------------------------
    // grant state
    // ------------------------------
    logic    gnt_vld;     // a handshake is open
    wr_src_t gnt_src;     // owner of the open handshake
    logic    pick_flush;
    logic    pick_host;

    // new grant only with the port free, flush wins a tie
    assign pick_flush = !gnt_vld && flush.req;
    assign pick_host  = !gnt_vld && !flush.req && host.req;

    // write lands in the cycle ack is raised
    assign we      = pick_flush | pick_host;
    assign copy_en = pick_host;                           // flushes skip the copy
    assign waddr   = pick_flush ? flush.addr : host.addr;
    assign wdata   = pick_flush ? flush.data : host.data;

    // ack per requester follows the grant owner
    assign host.ack  = gnt_vld && (gnt_src == SRC_HOST);
    assign flush.ack = gnt_vld && (gnt_src == SRC_FLUSH);

    always_ff @(posedge sysclk)
    begin
        if (rst)
        begin
            gnt_vld <= 1'b0;
            gnt_src <= SRC_HOST;
        end
        else if (!gnt_vld)
        begin
            if (pick_flush)
            begin
                gnt_vld <= 1'b1;
                gnt_src <= SRC_FLUSH;
            end
            else if (pick_host)
            begin
                gnt_vld <= 1'b1;
                gnt_src <= SRC_HOST;
            end
        end
        else
        begin
            // hold until the winner lets req fall, then drop ack
            unique case (gnt_src)
                SRC_FLUSH: if (!flush.req) gnt_vld <= 1'b0;
                SRC_HOST:  if (!host.req)  gnt_vld <= 1'b0;
            endcase
        end
    end

endmodule

// File: src/dac_wr_if.sv
/*
 * regfile write request channel
 * one requester raises a four-phase req/ack write toward the arbiter
 */

`timescale 1ns/1ps

interface dac_wr_if
    import dac_pkg::*;
#(
    parameter int NUM_CHANNELS = 4
);

    localparam int CW = chan_w(NUM_CHANNELS);

    logic          req;   // held until ack seen
    logic [CW-1:0] addr;  // zero-based channel
    dac_word_t     data;  // word to store
    logic          ack;   // high from write cycle until req drops

    modport requester
    (
        output req,
        output addr,
        output data,
        input  ack
    );

    modport arbiter
    (
        input  req,
        input  addr,
        input  data,
        output ack
    );

endinterface

// File: src/dac_pkg.sv
/*
 * dac controller package
 * command codes, register address constants, command word type
 * and the channel index width shared by the controller blocks
 */

package dac_pkg;

    // ------------------------------
    // command word layout
    // ------------------------------
    // bits 23:20 command, 15:0 value, all else zero
    typedef logic [31:0] dac_word_t;

    localparam logic [3:0]  DAC_CMD_WRU  = 4'h3;      // write and update
    localparam logic [3:0]  DAC_CMD_NOP  = 4'hF;      // no operation
    localparam logic [15:0] DAC_VAL_INIT = 16'h8000;  // zero current

    // reset and flush contents of every channel
    localparam dac_word_t DAC_WORD_NOP = {8'h00, DAC_CMD_NOP, 4'h0, DAC_VAL_INIT};

    // ------------------------------
    // host register map
    // ------------------------------
    localparam logic [3:0] ADDR_MAIN    = 4'h0;  // reg_waddr[15:12]
    localparam logic [3:0] OFF_DAC_CTRL = 4'h1;  // reg_waddr[3:0]

    // who owns the regfile write port
    typedef enum logic
    {
        SRC_HOST  = 1'b0,
        SRC_FLUSH = 1'b1
    } wr_src_t;

    // write-and-update word around a host value
    function automatic dac_word_t dac_wru_word(input logic [15:0] val);
        return {8'h00, DAC_CMD_WRU, 4'h0, val};
    endfunction

    // zero-based channel index width, never below one bit
    function automatic int chan_w(input int num_channels);
        return (num_channels > 1) ? $clog2(num_channels) : 1;
    endfunction

endpackage
